/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0
TOP        ?= calc_tb
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* sources.f */
+incdir+src
src/axil_pkg.sv
src/calc_pkg.sv
src/calc_regs.sv
src/calc_engine.sv
src/calc_top.sv
verif/calc_checker.sv
verif/calc_tb.sv

/* src/axil_pkg.sv */
// axi4-lite channel bundles and response codes for the calculator slave port
`default_nettype none
`include "calc_settings.svh"

package axil_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  // host to slave
  typedef struct packed {
    logic                    aw_valid;
    logic [`CALC_ADDR_W-1:0] aw_addr;
    logic                    w_valid;
    logic [`AXIL_DATA_W-1:0] w_data;
    logic [`AXIL_STRB_W-1:0] w_strb;
    logic                    b_ready;
    logic                    ar_valid;
    logic [`CALC_ADDR_W-1:0] ar_addr;
    logic                    r_ready;
  } axil_req_t;

  // slave to host
  typedef struct packed {
    logic                    aw_ready;
    logic                    w_ready;
    logic                    b_valid;
    axil_resp_e              b_resp;
    logic                    ar_ready;
    logic                    r_valid;
    logic [`AXIL_DATA_W-1:0] r_data;
    axil_resp_e              r_resp;
  } axil_rsp_t;

endpackage

`default_nettype wire

/* src/calc_engine.sv */
// calculator engine: restoring divider with carry, overflow and divide-by-zero flags
`timescale 1ns/1ps
`default_nettype none
`include "calc_settings.svh"

module calc_engine (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                start,
  input  calc_pkg::calc_ops_t ops,
  output logic                done,
  output calc_pkg::calc_res_t res
);

  localparam int W     = `CALC_DATA_W;
  localparam int CNT_W = $clog2(W);

  calc_pkg::div_state_e state;
  logic [CNT_W-1:0]     step_cnt;
  logic [W-1:0]         quot;      // dividend shifts out, quotient bits shift in
  logic [W-1:0]         divisor;
  logic [W-1:0]         rem;
  logic                 ovf_q;
  logic                 err_q;

  logic [2*W-1:0]       prod;
  logic                 ovf_next;
  logic [W:0]           shifted;
  logic [W+1:0]         trial;

  // overflow rule on the incoming operands
  always_comb begin
    prod     = {{W{1'b0}}, ops.op1} * {{W{1'b0}}, ops.op2};
    ovf_next = (|prod[2*W-1:W]) ||
               (prod[W-1] && (ops.op1[W-1] != ops.op2[W-1]));
  end

  // one shift-subtract step
  always_comb begin
    shifted = {rem, quot[W-1]};
    trial   = {1'b0, shifted} - {2'b00, divisor};  // msb set means borrow
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= calc_pkg::IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        calc_pkg::IDLE: begin
          if (start) begin
            state    <= calc_pkg::RUN;
            step_cnt <= '0;
          end
        end
        calc_pkg::RUN: begin
          step_cnt <= step_cnt + 1'b1;
          if (step_cnt == CNT_W'(W - 1)) begin
            state <= calc_pkg::DONE;
          end
        end
        calc_pkg::DONE: state <= calc_pkg::IDLE;
        default:        state <= calc_pkg::IDLE;
      endcase
    end
  end

  // datapath, loaded on start
  always_ff @(posedge clk) begin
    if ((state == calc_pkg::IDLE) && start) begin
      quot    <= ops.op1;
      divisor <= ops.op2;
      rem     <= '0;
      ovf_q   <= ovf_next;
      err_q   <= (ops.op2 == '0);
    end else if (state == calc_pkg::RUN) begin
      if (trial[W+1]) begin
        rem  <= shifted[W-1:0];            // restore
        quot <= {quot[W-2:0], 1'b0};
      end else begin
        rem  <= trial[W-1:0];
        quot <= {quot[W-2:0], 1'b1};
      end
    end
  end

  assign done = (state == calc_pkg::DONE);

  // zero divisor forces quotient and carry low
  always_comb begin
    res.quotient = err_q ? '0 : quot;
    res.carry    = err_q ? 1'b0 : rem[W-1];
    res.overflow = ovf_q;
    res.error    = err_q;
  end

endmodule

`default_nettype wire

/* src/calc_pkg.sv */
// calculator types: operand pair, result bundle and divider states
`default_nettype none
`include "calc_settings.svh"

package calc_pkg;

  // op1 sits in the low byte, same as the OPS register layout
  typedef struct packed {
    logic [`CALC_DATA_W-1:0] op2;   // divisor
    logic [`CALC_DATA_W-1:0] op1;   // dividend
  } calc_ops_t;

  typedef struct packed {
    logic [`CALC_DATA_W-1:0] quotient;
    logic                    carry;     // remainder msb
    logic                    overflow;  // from the product of op1 and op2
    logic                    error;     // divisor was zero
  } calc_res_t;

  typedef enum logic [1:0] {
    IDLE = 2'b00,
    RUN  = 2'b01,
    DONE = 2'b10
  } div_state_e;

endpackage

`default_nettype wire

/* src/calc_regs.sv */
// calculator register block: axi4-lite slave with operand, status and result registers
`timescale 1ns/1ps
`default_nettype none
`include "calc_settings.svh"

module calc_regs (
  input  logic                clk,
  input  logic                arst_n,
  input  axil_pkg::axil_req_t axil_req,
  output axil_pkg::axil_rsp_t axil_rsp,
  output logic                start,
  output calc_pkg::calc_ops_t ops,
  input  logic                done,
  input  calc_pkg::calc_res_t res
);

  logic                    wr_accept;
  logic                    rd_accept;
  logic                    wr_ops_ok;
  logic                    b_valid;
  logic                    r_valid;
  axil_pkg::axil_resp_e    b_resp;
  axil_pkg::axil_resp_e    r_resp;
  logic [`AXIL_DATA_W-1:0] r_data;
  logic [`AXIL_DATA_W-1:0] res_word;
  logic                    busy;
  calc_pkg::calc_res_t     res_q;

  // aw and w taken together, one write in flight
  assign wr_accept = axil_req.aw_valid && axil_req.w_valid && !b_valid;
  assign rd_accept = axil_req.ar_valid && !r_valid;

  // only a full-word OPS write while idle starts the engine
  assign wr_ops_ok = (axil_req.aw_addr == `CALC_REG_OPS) &&
                     (&axil_req.w_strb) && !busy;

  // RES read layout
  always_comb begin
    res_word                   = '0;
    res_word[16]               = busy;
    res_word[11]               = res_q.error;
    res_word[10]               = res_q.overflow;
    res_word[9]                = res_q.carry;
    res_word[`CALC_DATA_W-1:0] = res_q.quotient;
  end

  // handshake and engine control
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      b_valid <= 1'b0;
      r_valid <= 1'b0;
      start   <= 1'b0;
      busy    <= 1'b0;
      ops     <= '0;
      res_q   <= '0;
    end else begin
      start <= 1'b0;  // single cycle pulse

      if (wr_accept) begin
        b_valid <= 1'b1;
      end else if (axil_req.b_ready) begin
        b_valid <= 1'b0;
      end

      if (rd_accept) begin
        r_valid <= 1'b1;
      end else if (axil_req.r_ready) begin
        r_valid <= 1'b0;
      end

      if (wr_accept && wr_ops_ok) begin
        ops   <= axil_req.w_data[2*`CALC_DATA_W-1:0];
        start <= 1'b1;
        busy  <= 1'b1;
      end else if (done) begin
        busy  <= 1'b0;   // clears the cycle after done
      end

      if (done) begin
        res_q <= res;
      end
    end
  end

  // response payload, only meaningful while the matching valid is high
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      b_resp <= wr_ops_ok ? axil_pkg::OKAY : axil_pkg::SLVERR;
    end
    if (rd_accept) begin
      case (axil_req.ar_addr)
        `CALC_REG_OPS: begin
          r_data <= {16'h0000, ops};
          r_resp <= axil_pkg::OKAY;
        end
        `CALC_REG_RES: begin
          r_data <= res_word;
          r_resp <= axil_pkg::OKAY;
        end
        default: begin
          r_data <= '0;
          r_resp <= axil_pkg::SLVERR;  // unmapped
        end
      endcase
    end
  end

  always_comb begin
    axil_rsp.aw_ready = wr_accept;
    axil_rsp.w_ready  = wr_accept;
    axil_rsp.b_valid  = b_valid;
    axil_rsp.b_resp   = b_resp;
    axil_rsp.ar_ready = rd_accept;
    axil_rsp.r_valid  = r_valid;
    axil_rsp.r_data   = r_data;
    axil_rsp.r_resp   = r_resp;
  end

endmodule

`default_nettype wire

/* src/calc_settings.svh */
// calculator settings: operand width, bus widths and register offsets
`ifndef CALC_SETTINGS_SVH
`define CALC_SETTINGS_SVH

// operand and quotient width
`define CALC_DATA_W 8

// axi4-lite bus geometry
`define CALC_ADDR_W 4
`define AXIL_DATA_W 32
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// register map
`define CALC_REG_OPS 4'h0   // operands, write starts a division
`define CALC_REG_RES 4'h4   // busy, flags and quotient

`endif

/* src/calc_top.sv */
// calculator top: axi4-lite register block driving the divider engine
`timescale 1ns/1ps
`default_nettype none

module calc_top (
  input  logic                clk,
  input  logic                arst_n,
  input  axil_pkg::axil_req_t axil_req,
  output axil_pkg::axil_rsp_t axil_rsp
);

  logic                start;
  logic                done;
  calc_pkg::calc_ops_t ops;
  calc_pkg::calc_res_t res;

  calc_regs u_regs (
    .clk      (clk),
    .arst_n   (arst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .start    (start),
    .ops      (ops),
    .done     (done),
    .res      (res)
  );

  // divider, 9 cycles from start to done
  calc_engine u_engine (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .ops    (ops),
    .done   (done),
    .res    (res)
  );

endmodule

`default_nettype wire

/* verif/calc_checker.sv */
// calculator reference model: expected quotient, carry, overflow and divide-by-zero flags
`timescale 1ns/1ps
`default_nettype none
`include "calc_settings.svh"

module calc_checker (
  input  calc_pkg::calc_ops_t ops,
  output calc_pkg::calc_res_t exp_res
);

  localparam int W = `CALC_DATA_W;

  logic [2*W-1:0] product;
  logic [W-1:0]   remainder;

  always_comb begin
    product = {{W{1'b0}}, ops.op1} * {{W{1'b0}}, ops.op2};

    // high byte set, or low byte msb with operand msbs that differ
    exp_res.overflow = (product[2*W-1:W] != '0) ||
                       (product[W-1] && (ops.op1[W-1] != ops.op2[W-1]));

    if (ops.op2 == '0) begin
      remainder        = '0;
      exp_res.quotient = '0;
      exp_res.error    = 1'b1;   // zero divisor
    end else begin
      remainder        = ops.op1 % ops.op2;
      exp_res.quotient = ops.op1 / ops.op2;
      exp_res.error    = 1'b0;
    end

    exp_res.carry = remainder[W-1];
  end

endmodule

`default_nettype wire

/* verif/calc_patterns.txt */
// columns, all hex: op1 op2 quotient carry overflow error
// carry is remainder bit 7, overflow follows the 16-bit product rule
64 01 64 0 0 0
81 01 81 0 1 0
05 09 00 0 0 0
90 f0 00 1 1 0
37 37 01 0 1 0
0a 0a 01 0 0 0
2a 00 00 0 0 1
00 00 00 0 0 1
20 10 02 0 1 0
43 02 21 0 0 0
01 85 00 0 1 0
fe 07 24 0 1 0
c8 c9 00 1 1 0
07 03 02 0 0 0
0f 11 00 0 0 0
01 ff 00 0 1 0

/* verif/calc_tb.sv */
// calculator testbench: axi4-lite host driving directed and random divisions
`timescale 1ns/1ps
`default_nettype none
`include "calc_settings.svh"

module calc_tb;

  localparam int MAX_VEC   = 32;
  localparam int NUM_RAND  = 40;
  localparam int NUM_EXTRA = 10;   // register and busy tests

  logic                clk;
  logic                arst_n;
  axil_pkg::axil_req_t axil_req;
  axil_pkg::axil_rsp_t axil_rsp;
  calc_pkg::calc_ops_t chk_ops;
  calc_pkg::calc_res_t chk_res;

  logic [8:0] pat_mem [0:6*MAX_VEC-1];   // bit 8 marks an unused entry
  int         num_vec;
  int         cycle_count;
  int         cycle_limit;
  integer     seed;

  calc_top u_dut (
    .clk      (clk),
    .arst_n   (arst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp)
  );

  calc_checker u_checker (
    .ops     (chk_ops),
    .exp_res (chk_res)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      abort_run("stopping at first mismatch");
    end
  endtask

  // RES register layout
  function automatic logic [31:0] pack_res(input logic [7:0] q, input logic c,
                                           input logic o, input logic e);
    return {20'h00000, e, o, c, 1'b0, q};
  endfunction

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      abort_run($sformatf("timeout, run still going after %0d cycles", cycle_count));
    end
  end

  task automatic axil_write(input logic [`CALC_ADDR_W-1:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, output axil_pkg::axil_resp_e resp);
    @(posedge clk);
    #1;
    axil_req.aw_valid = 1'b1;
    axil_req.aw_addr  = addr;
    axil_req.w_valid  = 1'b1;
    axil_req.w_data   = data;
    axil_req.w_strb   = strb;
    axil_req.b_ready  = 1'b1;
    @(negedge clk);
    while (!axil_rsp.aw_ready) begin
      @(negedge clk);
    end
    check_value("write w_ready", 32'd1, 32'(axil_rsp.w_ready));
    @(posedge clk);   // aw and w handshake
    #1;
    axil_req.aw_valid = 1'b0;
    axil_req.w_valid  = 1'b0;
    @(negedge clk);
    while (!axil_rsp.b_valid) begin
      @(negedge clk);
    end
    resp = axil_rsp.b_resp;
    @(posedge clk);   // b handshake
    #1;
    axil_req.b_ready = 1'b0;
  endtask

  task automatic axil_read(input logic [`CALC_ADDR_W-1:0] addr, output logic [31:0] data,
                           output axil_pkg::axil_resp_e resp);
    @(posedge clk);
    #1;
    axil_req.ar_valid = 1'b1;
    axil_req.ar_addr  = addr;
    axil_req.r_ready  = 1'b1;
    @(negedge clk);
    while (!axil_rsp.ar_ready) begin
      @(negedge clk);
    end
    @(posedge clk);   // ar handshake
    #1;
    axil_req.ar_valid = 1'b0;
    @(negedge clk);
    while (!axil_rsp.r_valid) begin
      @(negedge clk);
    end
    data = axil_rsp.r_data;
    resp = axil_rsp.r_resp;
    @(posedge clk);   // r handshake
    #1;
    axil_req.r_ready = 1'b0;
  endtask

  // poll RES until the engine has finished
  task automatic wait_idle(input string name, output logic [31:0] word);
    axil_pkg::axil_resp_e resp;
    word = 32'h0001_0000;
    while (word[16]) begin
      axil_read(`CALC_REG_RES, word, resp);
      check_value({name, " res resp"}, 32'(axil_pkg::OKAY), 32'(resp));
    end
  endtask

  task automatic run_calc(input string name, input logic [7:0] op1, input logic [7:0] op2,
                          output logic [31:0] word);
    axil_pkg::axil_resp_e resp;
    axil_write(`CALC_REG_OPS, {16'h0000, op2, op1}, 4'hf, resp);
    check_value({name, " ops resp"}, 32'(axil_pkg::OKAY), 32'(resp));
    wait_idle(name, word);
  endtask

  initial begin
    logic [31:0]          word;
    logic [31:0]          exp_word;
    axil_pkg::axil_resp_e resp;
    integer               rnd;
    int                   base;
    string                name;

    axil_req    = '0;
    arst_n      = 1'b0;
    chk_ops     = '0;
    seed        = 33;

    for (int i = 0; i < 6 * MAX_VEC; i++) begin
      pat_mem[i] = {1'b1, i[7:0]};
    end
    $readmemh("verif/calc_patterns.txt", pat_mem);
    num_vec = 0;
    while (num_vec < MAX_VEC && !pat_mem[6*num_vec][8]) begin
      num_vec++;
    end
    cycle_limit = 40 * (num_vec + NUM_RAND + NUM_EXTRA) + 200;

    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // nothing computed yet
    axil_read(`CALC_REG_RES, word, resp);
    check_value("reset res", 32'h0, word);
    check_value("reset res resp", 32'(axil_pkg::OKAY), 32'(resp));

    for (int v = 0; v < num_vec; v++) begin
      base        = 6 * v;
      name        = $sformatf("vector %0d", v);
      chk_ops.op1 = pat_mem[base][7:0];
      chk_ops.op2 = pat_mem[base+1][7:0];
      exp_word    = pack_res(pat_mem[base+2][7:0], pat_mem[base+3][0],
                             pat_mem[base+4][0], pat_mem[base+5][0]);
      run_calc(name, chk_ops.op1, chk_ops.op2, word);
      check_value(name, exp_word, word);
      check_value({name, " model"}, exp_word,
                  pack_res(chk_res.quotient, chk_res.carry, chk_res.overflow, chk_res.error));
    end

    for (int n = 0; n < NUM_RAND; n++) begin
      rnd         = $random(seed);
      name        = $sformatf("random %0d", n);
      chk_ops.op1 = rnd[7:0];
      chk_ops.op2 = rnd[15:8];
      run_calc(name, chk_ops.op1, chk_ops.op2, word);
      check_value(name, pack_res(chk_res.quotient, chk_res.carry, chk_res.overflow,
                                 chk_res.error), word);
    end

    // second write lands while the first is still running
    chk_ops.op1 = 8'hc8;
    chk_ops.op2 = 8'h0b;
    axil_write(`CALC_REG_OPS, {16'h0000, chk_ops.op2, chk_ops.op1}, 4'hf, resp);
    check_value("busy first resp", 32'(axil_pkg::OKAY), 32'(resp));
    axil_write(`CALC_REG_OPS, 32'h0000_0307, 4'hf, resp);
    check_value("busy second resp", 32'(axil_pkg::SLVERR), 32'(resp));
    wait_idle("busy", word);
    exp_word = pack_res(chk_res.quotient, chk_res.carry, chk_res.overflow, chk_res.error);
    check_value("busy result", exp_word, word);

    axil_read(`CALC_REG_OPS, word, resp);
    check_value("ops readback", {16'h0000, chk_ops.op2, chk_ops.op1}, word);
    check_value("ops readback resp", 32'(axil_pkg::OKAY), 32'(resp));

    axil_write(`CALC_REG_OPS, 32'h0000_0204, 4'b0111, resp);
    check_value("strobe low resp", 32'(axil_pkg::SLVERR), 32'(resp));
    axil_write(4'hc, 32'h0000_0204, 4'hf, resp);
    check_value("unmapped write resp", 32'(axil_pkg::SLVERR), 32'(resp));
    axil_read(4'h8, word, resp);
    check_value("unmapped read resp", 32'(axil_pkg::SLVERR), 32'(resp));

    // rejected writes must leave engine idle and registers unchanged
    axil_read(`CALC_REG_RES, word, resp);
    check_value("res after rejects", exp_word, word);
    axil_read(`CALC_REG_OPS, word, resp);
    check_value("ops after rejects", {16'h0000, chk_ops.op2, chk_ops.op1}, word);

    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire
